/* src/lfsr_consts.svh */
// widths, polynomials, seeds and lock threshold for the scrambler link
`ifndef LFSR_CONSTS_SVH
`define LFSR_CONSTS_SVH

// one line word per clock
`define LINE_W 64

// 64b66b scrambler, x^58 + x^39 + 1
// top term implied, bit 39 and the +1 term listed
`define SCR_W 58
`define SCR_POLY 58'h8000000001
// same start value on both ends of the link
`define SCR_INIT 58'h3ffffffffffffff

// prbs31, x^31 + x^28 + 1
`define PRBS_W 31
`define PRBS_POLY 31'h10000001
// any nonzero seed will do
`define PRBS_INIT 31'h7fffffff

// clean words in a row before the checker reports lock
`define PRBS_LOCK_WORDS 4

// width of the saturating bit error counter
`define ERR_CNT_W 16

`endif

/* src/link_pkg.sv */
// line side word and scrambler state types
`include "lfsr_consts.svh"

package link_pkg;

    // one 64 bit word on the line or payload side
    // bit 0 goes first in time on the serial path
    typedef logic [`LINE_W-1:0] line_word_t;

    // scrambler and descrambler shift register
    // bit 0 holds the most recent line bit
    typedef logic [`SCR_W-1:0] scr_state_t;

endpackage

/* src/prbs_pkg.sv */
// prbs state, bit error count and per word mismatch count types
`include "lfsr_consts.svh"

package prbs_pkg;

    // prbs31 shift register, generator and checker history
    typedef logic [`PRBS_W-1:0] prbs_state_t;

    // total mismatching bits, sticks at all ones
    typedef logic [`ERR_CNT_W-1:0] err_cnt_t;

    // mismatching bits in one word, 0 to 64
    typedef logic [$clog2(`LINE_W+1)-1:0] bit_cnt_t;

endpackage

/* src/lfsr_step.sv */
// lfsr_step: combinational unrolled parallel lfsr next state and output
`timescale 1ns/1ps
`include "lfsr_consts.svh"

module lfsr_step #(
    // register width
    parameter int lfsr_w = `SCR_W,
    // taps, top term x^lfsr_w implied
    parameter logic [lfsr_w-1:0] lfsr_poly = `SCR_POLY,
    // 0 fibonacci (prbs, scramblers), 1 galois (crc)
    parameter bit galois = 1'b0,
    // 1 takes data bit 0 first in time, else msb first
    parameter bit reverse = 1'b0,
    // one shift per data bit
    parameter int data_w = `LINE_W,
    // 1 shifts the raw input bits in (feed forward)
    // 0 shifts the output bits back in (feedback)
    parameter bit data_in_en = 1'b0
) (
    input  logic [lfsr_w-1:0] state_in,
    input  logic [data_w-1:0] data_in,
    output logic [lfsr_w-1:0] state_out,
    output logic [data_w-1:0] data_out
);

    // state bit 0 is the newest bit, bit lfsr_w-1 the oldest
    //
    // fibonacci: fb = s[w-1] ^ s[j-1] for each tap j
    //   with data_in tied to zero this is a plain prbs source
    //   feedback mode gives a self-sync scrambler
    //   feed forward gives the matching descrambler or prbs checker
    // galois: fb = s[w-1], polynomial folded in when the fed bit is set
    always_comb begin : unroll
        logic [lfsr_w-1:0] s;
        logic              fb;
        logic              o;
        logic              feed;
        int                idx;

        s = state_in;
        data_out = '0;
        for (int i = 0; i < data_w; i++) begin
            // bit order on the wire
            idx = reverse ? i : data_w - 1 - i;

            fb = s[lfsr_w-1];
            if (!galois) begin
                for (int j = 1; j < lfsr_w; j++) begin
                    if (lfsr_poly[j]) begin
                        fb = fb ^ s[j-1];
                    end
                end
            end

            // output bit is always data xor feedback
            o = data_in[idx] ^ fb;
            data_out[idx] = o;

            // what goes into the register
            feed = data_in_en ? data_in[idx] : o;

            if (galois) begin
                s = {s[lfsr_w-2:0], 1'b0} ^ (feed ? lfsr_poly : '0);
            end else begin
                s = {s[lfsr_w-2:0], feed};
            end
        end
        state_out = s;
    end

endmodule

/* src/prbs_gen.sv */
// prbs_gen: prbs31 word generator, 64 bits per enabled cycle
`timescale 1ns/1ps
`include "lfsr_consts.svh"

module prbs_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    output link_pkg::line_word_t data,
    output logic                 valid
);

    prbs_pkg::prbs_state_t state;
    prbs_pkg::prbs_state_t state_next;
    link_pkg::line_word_t  word;

    // free running fibonacci, nothing fed in
    // bit 0 first, same order as the scrambler
    lfsr_step #(
        .lfsr_w    (`PRBS_W),
        .lfsr_poly (`PRBS_POLY),
        .galois    (1'b0),
        .reverse   (1'b1),
        .data_w    (`LINE_W),
        .data_in_en(1'b0)
    ) u_step (
        .state_in (state),
        .data_in  ('0),
        .state_out(state_next),
        .data_out (word)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= `PRBS_INIT;
            data <= '0;
            valid <= 1'b0;
        end else begin
            valid <= en;
            // gaps just hold the sequence
            if (en) begin
                state <= state_next;
                data <= word;
            end
        end
    end

    // all zero state would lock the generator up for good
    a_state_nonzero: assert property (
        @(posedge clk) disable iff (rst) state != '0
    ) else $error("prbs generator state stuck at zero");

endmodule

/* src/lfsr_scramble.sv */
// lfsr_scramble: registered self-synchronizing 64b66b word scrambler
`timescale 1ns/1ps
`include "lfsr_consts.svh"

module lfsr_scramble (
    input  logic                 clk,
    input  logic                 rst,
    input  link_pkg::line_word_t data_in,
    input  logic                 data_in_valid,
    output link_pkg::line_word_t data_out,
    output logic                 data_out_valid
);

    link_pkg::scr_state_t state;
    link_pkg::scr_state_t state_next;
    link_pkg::line_word_t scrambled;

    // feedback mode, scrambled bits go back into the register
    // so the far end syncs from the line alone
    lfsr_step #(
        .lfsr_w    (`SCR_W),
        .lfsr_poly (`SCR_POLY),
        .galois    (1'b0),
        .reverse   (1'b1),
        .data_w    (`LINE_W),
        .data_in_en(1'b0)
    ) u_step (
        .state_in (state),
        .data_in  (data_in),
        .state_out(state_next),
        .data_out (scrambled)
    );

    // state only moves on accepted words
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= `SCR_INIT;
            data_out <= '0;
            data_out_valid <= 1'b0;
        end else begin
            data_out_valid <= data_in_valid;
            if (data_in_valid) begin
                state <= state_next;
                data_out <= scrambled;
            end
        end
    end

    // register holds the last 58 scrambled bits
    // newest in bit 0, oldest in bit 57
    a_state_from_line: assert property (
        @(posedge clk) disable iff (rst)
        data_in_valid |=> state[0] == data_out[`LINE_W-1]
                          && state[`SCR_W-1] == data_out[`LINE_W-`SCR_W]
    ) else $error("scrambler state not fed from its own output");

endmodule

/* src/lfsr_descramble.sv */
// lfsr_descramble: registered self-synchronizing 64b66b word descrambler
`timescale 1ns/1ps
`include "lfsr_consts.svh"

module lfsr_descramble (
    input  logic                 clk,
    input  logic                 rst,
    input  link_pkg::line_word_t data_in,
    input  logic                 data_in_valid,
    output link_pkg::line_word_t data_out,
    output logic                 data_out_valid
);

    link_pkg::scr_state_t state;
    link_pkg::scr_state_t state_next;
    link_pkg::line_word_t plain;

    // feed forward, register holds the last 58 line bits
    // output = line ^ line[-39] ^ line[-58]
    // a bad line bit hits three payload bits, then falls out
    // clean again after one full word
    lfsr_step #(
        .lfsr_w    (`SCR_W),
        .lfsr_poly (`SCR_POLY),
        .galois    (1'b0),
        .reverse   (1'b1),
        .data_w    (`LINE_W),
        .data_in_en(1'b1)
    ) u_step (
        .state_in (state),
        .data_in  (data_in),
        .state_out(state_next),
        .data_out (plain)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            // matches the scrambler start, so no garbage word after reset
            state <= `SCR_INIT;
            data_out <= '0;
            data_out_valid <= 1'b0;
        end else begin
            data_out_valid <= data_in_valid;
            // idle cycles leave history untouched
            if (data_in_valid) begin
                state <= state_next;
                data_out <= plain;
            end
        end
    end

endmodule

/* src/prbs_check.sv */
// prbs_check: self-synchronizing prbs31 checker, bit error count and lock
`timescale 1ns/1ps
`include "lfsr_consts.svh"

module prbs_check (
    input  logic                 clk,
    input  logic                 rst,
    input  link_pkg::line_word_t data,
    input  logic                 valid,
    output prbs_pkg::err_cnt_t   err_count,
    output logic                 locked
);

    localparam int cnt_w = $bits(prbs_pkg::err_cnt_t);
    localparam int bc_w = $bits(prbs_pkg::bit_cnt_t);
    localparam int clean_w = $clog2(`PRBS_LOCK_WORDS + 1);

    prbs_pkg::prbs_state_t hist;
    prbs_pkg::prbs_state_t hist_next;
    link_pkg::line_word_t  miss;
    prbs_pkg::bit_cnt_t    miss_bits;
    logic [cnt_w:0]        sum;
    logic [clean_w-1:0]    clean_cnt;
    // history valid, first word after reset only fills it
    logic                  primed;

    // feed forward, history is the last 31 received bits
    // miss = rx ^ rx[-28] ^ rx[-31], zero on a clean stream
    lfsr_step #(
        .lfsr_w    (`PRBS_W),
        .lfsr_poly (`PRBS_POLY),
        .galois    (1'b0),
        .reverse   (1'b1),
        .data_w    (`LINE_W),
        .data_in_en(1'b1)
    ) u_step (
        .state_in (hist),
        .data_in  (data),
        .state_out(hist_next),
        .data_out (miss)
    );

    // popcount of the mismatch word
    always_comb begin
        miss_bits = '0;
        for (int i = 0; i < `LINE_W; i++) begin
            miss_bits = miss_bits + prbs_pkg::bit_cnt_t'(miss[i]);
        end
        // one spare bit catches overflow
        sum = {1'b0, err_count} + {{(cnt_w + 1 - bc_w){1'b0}}, miss_bits};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '0;
            primed <= 1'b0;
            clean_cnt <= '0;
            locked <= 1'b0;
            err_count <= '0;
        end else if (valid) begin
            hist <= hist_next;
            primed <= 1'b1;
            if (primed) begin
                if (miss_bits != '0) begin
                    // any hit drops lock and restarts the run
                    clean_cnt <= '0;
                    locked <= 1'b0;
                    err_count <= sum[cnt_w] ? '1 : sum[cnt_w-1:0];
                end else begin
                    if (clean_cnt != clean_w'(`PRBS_LOCK_WORDS)) begin
                        clean_cnt <= clean_cnt + 1'b1;
                    end
                    if (clean_cnt == clean_w'(`PRBS_LOCK_WORDS - 1)) begin
                        locked <= 1'b1;
                    end
                end
            end
        end
    end

    // counter only goes up or saturates, reset aside
    a_count_monotonic: assert property (
        @(posedge clk) !rst |=> err_count >= $past(err_count)
    ) else $error("prbs checker error count went down");

endmodule

/* src/scramble_link_top.sv */
// scramble_link_top: prbs source, scrambler, error injection, descrambler, checker
`timescale 1ns/1ps

module scramble_link_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 inject_err,
    output link_pkg::line_word_t line_data,
    output link_pkg::line_word_t rx_data,
    output logic                 rx_valid,
    output prbs_pkg::err_cnt_t   err_count,
    output logic                 locked
);

    link_pkg::line_word_t gen_data;
    logic                 gen_valid;
    link_pkg::line_word_t scr_data;
    logic                 scr_valid;

    prbs_gen u_gen (
        .clk  (clk),
        .rst  (rst),
        .en   (en),
        .data (gen_data),
        .valid(gen_valid)
    );

    lfsr_scramble u_scr (
        .clk           (clk),
        .rst           (rst),
        .data_in       (gen_data),
        .data_in_valid (gen_valid),
        .data_out      (scr_data),
        .data_out_valid(scr_valid)
    );

    // flip line bit 0 of the current word
    // zero extend puts the strobe on bit 0 only
    assign line_data = scr_data ^ link_pkg::line_word_t'(inject_err);

    lfsr_descramble u_descr (
        .clk           (clk),
        .rst           (rst),
        .data_in       (line_data),
        .data_in_valid (scr_valid),
        .data_out      (rx_data),
        .data_out_valid(rx_valid)
    );

    prbs_check u_check (
        .clk      (clk),
        .rst      (rst),
        .data     (rx_data),
        .valid    (rx_valid),
        .err_count(err_count),
        .locked   (locked)
    );

endmodule

/* sim/tb_scramble_link.sv */
// testbench for the scrambler link: clock, stimulus, galois random source, assertions, report
`timescale 1ns/1ps
`include "lfsr_consts.svh"

module tb_scramble_link;

    // test lengths in cycles
    localparam int rst_cycles = 3;
    localparam int lock_wait = 12;
    localparam int hold_words = 200;
    localparam int gap_cycles = 500;
    localparam int lead_cycles = 8;
    localparam int inj_count = 12;
    localparam int inj_space = 12;
    localparam int drain_cycles = 8;
    localparam int test_cycles = rst_cycles + lock_wait + hold_words + gap_cycles
                               + lead_cycles + inj_count * inj_space + drain_cycles;
    // twice the full test length
    localparam int max_cycles = 2 * test_cycles;

    logic                 clk;
    logic                 rst;
    logic                 en;
    logic                 inject_err;
    link_pkg::line_word_t line_data;
    link_pkg::line_word_t rx_data;
    logic                 rx_valid;
    prbs_pkg::err_cnt_t   err_count;
    logic                 locked;

    // random source state
    logic [31:0]          rng;
    int                   fail_errs;
    int                   other_errs;
    int                   cycles;
    // phase flags, set by the stimulus
    logic                 no_errors;
    logic                 prbs_phase;
    // en history, line valid two cycles behind, rx valid three
    logic [2:0]           en_pipe;
    logic                 line_live;
    prbs_pkg::err_cnt_t   exp_count;
    link_pkg::line_word_t prev_rx;
    logic                 prev_ok;

    scramble_link_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .inject_err(inject_err),
        .line_data (line_data),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .err_count (err_count),
        .locked    (locked)
    );

    always #20 clk = ~clk;

    // right shift galois, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one bit per step
    task automatic take_bit(output bit b);
        b = rng[0];
        rng = galois_step(rng);
    endtask

    // each bit equals the bits 28 and 31 places earlier xored
    function automatic bit prbs_follows(input logic [63:0] cur, input logic [63:0] prev);
        logic [127:0] x;
        bit           ok;
        x = {cur, prev};
        ok = 1'b1;
        for (int j = 64; j < 128; j++) begin
            if (x[j] != (x[j-28] ^ x[j-31])) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // en high on about three cycles in four
    task automatic run_gaps(input int n);
        bit b0;
        bit b1;
        for (int i = 0; i < n; i++) begin
            take_bit(b0);
            take_bit(b1);
            en = b0 | b1;
            @(negedge clk);
        end
    endtask

    // one line bit flipped for one word
    task automatic inject_single();
        inject_err = 1'b1;
        @(negedge clk);
        inject_err = 1'b0;
    endtask

    assign line_live = en_pipe[1];

    // expected count and word history, sampled like the assertions
    always @(posedge clk) begin
        if (rst) begin
            en_pipe <= '0;
            exp_count <= '0;
            prev_rx <= '0;
            prev_ok <= 1'b0;
        end else begin
            en_pipe <= {en_pipe[1:0], en};
            // three descrambler taps times three checker taps
            if (inject_err && line_live) begin
                exp_count <= exp_count + 16'd9;
            end
            if (rx_valid) begin
                prev_rx <= rx_data;
                prev_ok <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("errors: %0d value mismatches, %0d other failures", fail_errs, other_errs);
            $display("TB FAILED");
            $finish;
        end
    end

    // lock soon after reset
    a_lock_up: assert property (
        @(posedge clk) $fell(rst) |-> ##[1:lock_wait] locked
    ) else begin
        other_errs++;
        $display("checker did not lock after reset");
    end

    a_lock_hold: assert property (
        @(posedge clk) disable iff (rst) (no_errors && locked) |=> locked
    ) else begin
        other_errs++;
        $display("checker lost lock on a clean stream");
    end

    a_no_errors: assert property (
        @(posedge clk) disable iff (rst) no_errors |-> err_count == '0
    ) else begin
        fail_errs++;
        $display("Fail err_count: got %h expected %h", $sampled(err_count), 16'h0);
    end

    // three cycle pipe, one word out per enabled cycle
    a_valid_pipe: assert property (
        @(posedge clk) disable iff (rst) rx_valid == en_pipe[2]
    ) else begin
        fail_errs++;
        $display("Fail rx_valid: got %h expected %h", $sampled(rx_valid), $sampled(en_pipe[2]));
    end

    // rx word against the line word it came from
    a_scrambled: assert property (
        @(posedge clk) disable iff (rst) rx_valid |-> rx_data != $past(line_data)
    ) else begin
        fail_errs++;
        $display("Fail line_data: %h equals rx_data %h", $past(line_data), $sampled(rx_data));
    end

    a_prbs_seq: assert property (
        @(posedge clk) disable iff (rst)
        (rx_valid && prev_ok && prbs_phase) |-> prbs_follows(rx_data, prev_rx)
    ) else begin
        fail_errs++;
        $display("Fail rx_data: %h after %h breaks the prbs31 recurrence",
                 $sampled(rx_data), $sampled(prev_rx));
    end

    // nine more errors, then no change through relock
    a_count_step: assert property (
        @(posedge clk) disable iff (rst)
        (inject_err && line_live) |-> ##3 (err_count == exp_count) [*(`PRBS_LOCK_WORDS + 1)]
    ) else begin
        fail_errs++;
        $display("Fail err_count: got %h expected %h", $sampled(err_count), exp_count);
    end

    // two errored words, then the clean run
    a_relock: assert property (
        @(posedge clk) disable iff (rst)
        (inject_err && line_live) |-> ##2 (!locked) [*(`PRBS_LOCK_WORDS + 1)] ##1 locked
    ) else begin
        other_errs++;
        $display("checker lock did not drop and come back on time after an injection");
    end

    initial begin
        int waited;
        clk = 1'b0;
        rst = 1'b1;
        en = 1'b0;
        inject_err = 1'b0;
        rng = 32'h2503_f8b3;
        fail_errs = 0;
        other_errs = 0;
        cycles = 0;
        no_errors = 1'b1;
        prbs_phase = 1'b1;
        waited = 0;

        repeat (rst_cycles) @(negedge clk);
        rst = 1'b0;

        // steady stream, lock then hold
        en = 1'b1;
        while (!locked && waited < lock_wait) begin
            @(negedge clk);
            waited++;
        end
        repeat (hold_words) @(negedge clk);

        // random gaps in en
        run_gaps(gap_cycles);

        // single bit hits on a steady stream
        no_errors = 1'b0;
        prbs_phase = 1'b0;
        en = 1'b1;
        repeat (lead_cycles) @(negedge clk);
        repeat (inj_count) begin
            inject_single();
            repeat (inj_space - 1) @(negedge clk);
        end
        en = 1'b0;
        repeat (drain_cycles) @(negedge clk);

        $display("errors: %0d value mismatches, %0d other failures", fail_errs, other_errs);
        if (fail_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+src
src/link_pkg.sv
src/prbs_pkg.sv
src/lfsr_step.sv
src/prbs_gen.sv
src/lfsr_scramble.sv
src/lfsr_descramble.sv
src/prbs_check.sv
src/scramble_link_top.sv
sim/tb_scramble_link.sv

/* Bender.yml */
package:
  name: scramble_link

sources:
  - include_dirs:
      - src
    files:
      - src/link_pkg.sv
      - src/prbs_pkg.sv
      - src/lfsr_step.sv
      - src/prbs_gen.sv
      - src/lfsr_scramble.sv
      - src/lfsr_descramble.sv
      - src/prbs_check.sv
      - src/scramble_link_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/tb_scramble_link.sv
